//--- common/sdram_pkg.sv
/* Shared sizes, SDRAM timing, command and state enums,
   and the request and pin structs */
`default_nettype none

package sdram_pkg;

    localparam int sdram_aw = 22;  // 13-bit row + 9-bit column
    localparam int dw       = 16;
    localparam int nbanks   = 4;

    // SDRAM timing in clock cycles
    localparam int t_rcd     = 2;
    localparam int cas_lat   = 2;
    localparam int t_rp      = 2;
    localparam int t_rfc     = 6;
    localparam int t_wr      = 2;
    localparam int init_wait = 20;  // Short power-up wait for simulation

    // Video raster
    localparam int h_total  = 64;
    localparam int h_active = 48;
    localparam int v_total  = 16;
    localparam int v_active = 12;
    localparam int pxl_div  = 4;   // Clocks per pixel

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        NOP       = 4'b0111,
        ACTIVE    = 4'b0011,
        READ      = 4'b0101,
        WRITE     = 4'b0100,
        PRECHARGE = 4'b0010,
        REFRESH   = 4'b0001,
        MODE      = 4'b0000,
        INHIBIT   = 4'b1111
    } sdram_cmd_e;

    typedef enum logic [3:0] {
        INIT_WAIT, INIT_PRE, INIT_RFSH, INIT_MODE,
        IDLE, ACT_WAIT, RD_WAIT, WR_REC, RFSH_WAIT
    } ctrl_state_e;

    typedef struct packed {
        logic [sdram_aw-1:0] addr;
        logic                rd;
        logic                wr;
        logic [dw-1:0]       din;
        logic [1:0]          din_m;  // Active low byte enables
    } bank_req_t;

    typedef struct packed {
        logic [sdram_aw-1:0] addr;
        logic [1:0]          ba;
        logic [dw-1:0]       din;
        logic [1:0]          din_m;
        logic                we;
    } prog_req_t;

    typedef struct packed {
        logic [sdram_aw-1:0] addr;
        logic [1:0]          ba;
        logic                wr;
        logic [dw-1:0]       din;
        logic [1:0]          din_m;
        logic                valid;
    } sdram_req_t;

    typedef struct packed {
        sdram_cmd_e    cmd;
        logic [1:0]    ba;
        logic [12:0]   a;
        logic [1:0]    dqm;
        logic [dw-1:0] din;
        logic          dq_oe;
        logic          cke;
    } sdram_pins_t;

endpackage

`default_nettype wire

//--- sdram/sdram_ctrl.sv
/* Single-word SDRAM controller: init sequence, auto-precharge
   read and write, refresh on each line blank */
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl (
    input  wire                      clk,
    input  wire                      rst_n,
    input  sdram_pkg::sdram_req_t    req,
    input  logic                     rfsh,    // Line blank, refresh on its falling edge
    output logic                     accept,
    output logic                     done,
    output logic                     init,
    output logic [sdram_pkg::dw-1:0] dout,
    output sdram_pkg::sdram_pins_t   pins,
    input  logic [sdram_pkg::dw-1:0] dq_in
);
    import sdram_pkg::*;

    ctrl_state_e      state;
    logic [4:0]       cnt;         // Shared wait counter
    logic             init_rf2;    // Second init refresh issued
    logic             rfsh_l;
    logic             rfsh_pend;
    logic [cas_lat:0] rd_sr;       // READ position in the CAS pipeline

    // Column part of the accepted request
    logic [8:0]       lat_col;
    logic             lat_wr;
    logic [dw-1:0]    lat_din;
    logic [1:0]       lat_din_m;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= INIT_WAIT;
            cnt        <= 5'(init_wait - 1);
            init       <= 1'b1;
            init_rf2   <= 1'b0;
            accept     <= 1'b0;
            done       <= 1'b0;
            rfsh_l     <= 1'b1;
            rfsh_pend  <= 1'b0;
            rd_sr      <= '0;
            pins.cmd   <= NOP;
            pins.dq_oe <= 1'b0;
            pins.cke   <= 1'b1;
        end else begin
            pins.cmd   <= NOP;
            pins.dq_oe <= 1'b0;
            accept     <= 1'b0;
            done       <= 1'b0;
            rd_sr      <= {rd_sr[cas_lat-1:0], 1'b0};

            case (state)
                INIT_WAIT: begin
                    if (cnt == 5'd0) begin
                        pins.cmd <= PRECHARGE;
                        pins.a   <= 13'h0400;  // A10 selects all banks
                        cnt      <= 5'(t_rp - 1);
                        state    <= INIT_PRE;
                    end else begin
                        cnt <= cnt - 5'd1;
                    end
                end
                INIT_PRE: begin
                    if (cnt == 5'd0) begin
                        pins.cmd <= REFRESH;
                        cnt      <= 5'(t_rfc - 1);
                        state    <= INIT_RFSH;
                    end else begin
                        cnt <= cnt - 5'd1;
                    end
                end
                INIT_RFSH: begin
                    if (cnt == 5'd0 && !init_rf2) begin
                        pins.cmd <= REFRESH;
                        cnt      <= 5'(t_rfc - 1);
                        init_rf2 <= 1'b1;
                    end else if (cnt == 5'd0) begin
                        // Burst of 1, sequential, CL in A6:4
                        pins.cmd <= MODE;
                        pins.ba  <= 2'b00;
                        pins.a   <= 13'(cas_lat << 4);
                        state    <= INIT_MODE;
                    end else begin
                        cnt <= cnt - 5'd1;
                    end
                end
                INIT_MODE: begin
                    init  <= 1'b0;
                    state <= IDLE;
                end
                IDLE: begin
                    if (rfsh_pend) begin  // Refresh beats any request
                        pins.cmd  <= REFRESH;
                        rfsh_pend <= 1'b0;
                        cnt       <= 5'(t_rfc - 1);
                        state     <= RFSH_WAIT;
                    end else if (req.valid) begin
                        pins.cmd  <= ACTIVE;
                        pins.ba   <= req.ba;
                        pins.a    <= req.addr[sdram_aw-1:9];  // Row
                        accept    <= 1'b1;
                        lat_col   <= req.addr[8:0];
                        lat_wr    <= req.wr;
                        lat_din   <= req.din;
                        lat_din_m <= req.din_m;
                        cnt       <= 5'(t_rcd - 1);
                        state     <= ACT_WAIT;
                    end
                end
                ACT_WAIT: begin
                    if (cnt == 5'd0) begin
                        pins.a <= {2'b00, 1'b1, 1'b0, lat_col};  // A10 auto-precharge
                        if (lat_wr) begin
                            pins.cmd   <= WRITE;
                            pins.dq_oe <= 1'b1;
                            pins.din   <= lat_din;
                            pins.dqm   <= lat_din_m;  // Same polarity as DQM
                            done       <= 1'b1;
                            cnt        <= 5'(t_wr + t_rp - 1);
                            state      <= WR_REC;
                        end else begin
                            pins.cmd <= READ;
                            pins.dqm <= 2'b00;
                            rd_sr[0] <= 1'b1;
                            state    <= RD_WAIT;
                        end
                    end else begin
                        cnt <= cnt - 5'd1;
                    end
                end
                RD_WAIT: begin
                    if (rd_sr[cas_lat]) begin  // dq_in sampled this cycle
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                WR_REC, RFSH_WAIT: begin
                    if (cnt == 5'd0) state <= IDLE;
                    else cnt <= cnt - 5'd1;
                end
                default: state <= IDLE;
            endcase

            // Set after the case so a new blank is never lost
            rfsh_l <= rfsh;
            if (rfsh_l && !rfsh) rfsh_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_sr[cas_lat]) dout <= dq_in;
    end

endmodule

`default_nettype wire

//--- sdram/sdram_arb.sv
/* Arbiter between the programming port and four bank ports,
   with ack and rdy routing by held grant */
`timescale 1ns/1ps
`default_nettype none

module sdram_arb (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  sdram_pkg::bank_req_t [sdram_pkg::nbanks-1:0]  banks,
    input  sdram_pkg::prog_req_t                          prog,
    input  logic                                          prog_en,
    input  logic                                          accept,
    input  logic                                          done,
    output sdram_pkg::sdram_req_t                         sel,
    output logic [sdram_pkg::nbanks-1:0]                  ack,
    output logic [sdram_pkg::nbanks-1:0]                  rdy,
    output logic                                          prog_ack,
    output logic                                          prog_rdy
);
    import sdram_pkg::*;

    logic       busy;        // Access in flight, accept to done
    logic       grant_prog;
    logic [1:0] grant;
    logic [1:0] last;        // Last served bank
    logic [1:0] pick_idx;
    logic       pick_valid;

    // Round-robin search starting after the last served bank
    always_comb begin
        logic [1:0] idx;
        idx        = '0;
        pick_idx   = last;
        pick_valid = 1'b0;
        for (int i = 1; i <= nbanks; i++) begin
            idx = 2'(last + i);
            if (!pick_valid && (banks[idx].rd || banks[idx].wr)) begin
                pick_valid = 1'b1;
                pick_idx   = idx;
            end
        end
    end

    always_comb begin
        if (prog_en) begin  // Download owns the SDRAM
            sel.addr  = prog.addr;
            sel.ba    = prog.ba;
            sel.wr    = 1'b1;
            sel.din   = prog.din;
            sel.din_m = prog.din_m;
            sel.valid = prog.we && !busy && !accept;
        end else begin
            sel.addr  = banks[pick_idx].addr;
            sel.ba    = pick_idx;
            sel.wr    = banks[pick_idx].wr && (pick_idx == 2'd0);  // Only bank 0 writes
            sel.din   = banks[pick_idx].din;
            sel.din_m = banks[pick_idx].din_m;
            sel.valid = pick_valid && !busy && !accept;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            grant_prog <= 1'b0;
            grant      <= '0;
            last       <= 2'(nbanks - 1);  // First pick is bank 0
        end else begin
            if (!busy && !accept) begin  // Track what the controller may take
                grant      <= pick_idx;
                grant_prog <= prog_en;
            end
            if (accept) begin
                busy <= 1'b1;
                if (!grant_prog) last <= grant;
            end
            if (done) busy <= 1'b0;
        end
    end

    always_comb begin
        ack = '0;
        rdy = '0;
        if (!grant_prog) begin
            ack[grant] = accept;
            rdy[grant] = done;
        end
    end

    assign prog_ack = accept && grant_prog;
    assign prog_rdy = done && grant_prog;

endmodule

`default_nettype wire

//--- rtl/rom_loader.sv
/* ROM download path: host byte writes to masked 16-bit
   programming writes */
`timescale 1ns/1ps
`default_nettype none

module rom_loader (
    input  wire                  clk,
    input  wire                  rst_n,
    input  logic [24:0]          ioctl_addr,
    input  logic [7:0]           ioctl_dout,
    input  logic                 ioctl_wr,
    input  logic                 prog_ack,
    output sdram_pkg::prog_req_t prog,
    output logic                 dwnld_busy
);

    // Byte address: bank in 24:23, word in 22:1, byte lane in 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog.we <= 1'b0;
        end else begin
            if (ioctl_wr && !prog.we) begin
                prog.addr  <= ioctl_addr[22:1];
                prog.ba    <= ioctl_addr[24:23];
                prog.din   <= {2{ioctl_dout}};
                // Active low, odd bytes go to the high lane
                prog.din_m <= ioctl_addr[0] ? 2'b01 : 2'b10;
                prog.we    <= 1'b1;
            end else if (prog_ack) begin
                prog.we <= 1'b0;
            end
        end
    end

    assign dwnld_busy = prog.we;  // Pending until the arbiter takes it

endmodule

`default_nettype wire

//--- rtl/video_timing.sv
/* Pixel clock enables and raster counters with blanks and syncs */
`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  wire  clk,
    input  wire  rst_n,
    output logic pxl_cen,
    output logic pxl2_cen,
    output logic lhbl,
    output logic lvbl,
    output logic hs,
    output logic vs
);
    import sdram_pkg::*;

    logic [1:0] cen_cnt;
    logic [5:0] h_cnt;
    logic [3:0] v_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cen_cnt  <= '0;
            pxl_cen  <= 1'b0;
            pxl2_cen <= 1'b0;
            h_cnt    <= '0;
            v_cnt    <= '0;
        end else begin
            if (cen_cnt == 2'(pxl_div - 1)) cen_cnt <= '0;
            else cen_cnt <= cen_cnt + 2'd1;

            pxl_cen  <= cen_cnt == 2'(pxl_div - 1);
            pxl2_cen <= cen_cnt == 2'(pxl_div / 2 - 1) ||
                        cen_cnt == 2'(pxl_div - 1);  // Twice per pixel

            if (pxl_cen) begin
                if (h_cnt == 6'(h_total - 1)) begin
                    h_cnt <= '0;
                    if (v_cnt == 4'(v_total - 1)) v_cnt <= '0;
                    else v_cnt <= v_cnt + 4'd1;
                end else begin
                    h_cnt <= h_cnt + 6'd1;
                end
            end
        end
    end

    assign lhbl = h_cnt < 6'(h_active);
    assign lvbl = v_cnt < 4'(v_active);

    // HS sits 4 pixels into the line blank
    assign hs = h_cnt >= 6'(h_active + 4) && h_cnt < 6'(h_active + 8);
    // Vertical blank is only 4 lines, VS spans all of it
    assign vs = v_cnt >= 4'(v_active);

endmodule

`default_nettype wire

//--- rtl/game_test.sv
/* Framework top: ROM loader, SDRAM arbiter and controller,
   video timing */
`timescale 1ns/1ps
`default_nettype none

module game_test (
    input  wire                                           clk,
    input  wire                                           rst_n,
    // Game bank ports
    input  sdram_pkg::bank_req_t [sdram_pkg::nbanks-1:0]  banks,
    output logic [sdram_pkg::nbanks-1:0]                  ack,
    output logic [sdram_pkg::nbanks-1:0]                  rdy,
    output logic [sdram_pkg::dw-1:0]                      dout,
    // ROM download
    input  logic                                          downloading,
    input  logic [24:0]                                   ioctl_addr,
    input  logic [7:0]                                    ioctl_dout,
    input  logic                                          ioctl_wr,
    output logic                                          dwnld_busy,
    // SDRAM chip
    output logic                                          sdram_init,
    output sdram_pkg::sdram_pins_t                        pins,
    input  logic [sdram_pkg::dw-1:0]                      dq_in,
    // Video
    output logic                                          pxl_cen,
    output logic                                          pxl2_cen,
    output logic                                          lhbl,
    output logic                                          lvbl,
    output logic                                          hs,
    output logic                                          vs
);
    import sdram_pkg::*;

    prog_req_t  prog;
    logic       prog_ack;
    sdram_req_t sel;
    logic       accept;
    logic       done;

    rom_loader u_loader (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .ioctl_wr   ( ioctl_wr   ),
        .prog_ack   ( prog_ack   ),
        .prog       ( prog       ),
        .dwnld_busy ( dwnld_busy )
    );

    sdram_arb u_arb (
        .clk      ( clk                        ),
        .rst_n    ( rst_n                      ),
        .banks    ( banks                      ),
        .prog     ( prog                       ),
        .prog_en  ( downloading | dwnld_busy   ),  // Hold off banks until last write lands
        .accept   ( accept                     ),
        .done     ( done                       ),
        .sel      ( sel                        ),
        .ack      ( ack                        ),
        .rdy      ( rdy                        ),
        .prog_ack ( prog_ack                   ),
        .prog_rdy (                            )
    );

    sdram_ctrl u_sdram (
        .clk    ( clk        ),
        .rst_n  ( rst_n      ),
        .req    ( sel        ),
        .rfsh   ( lhbl       ),
        .accept ( accept     ),
        .done   ( done       ),
        .init   ( sdram_init ),
        .dout   ( dout       ),
        .pins   ( pins       ),
        .dq_in  ( dq_in      )
    );

    video_timing u_video (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .pxl2_cen ( pxl2_cen ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .hs       ( hs       ),
        .vs       ( vs       )
    );

endmodule

`default_nettype wire

//--- verification/sdram_model.sv
/* Behavioural SDRAM: command decode, byte-masked word store,
   read data after CAS latency 2 */
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  wire                    clk,
    input  sdram_pkg::sdram_pins_t pins,
    output logic [15:0]            dq_in
);
    import sdram_pkg::*;

    logic [15:0] mem [logic [23:0]];  // Key is {bank, row, column}
    logic [12:0] open_row [nbanks];
    logic [15:0] rd_d0;
    logic [15:0] rd_d1;

    // Unwritten words read back as a pattern of the full address
    function automatic logic [15:0] fill_word(input logic [23:0] k);
        return k[15:0] ^ {k[7:0], k[23:16]} ^ 16'h6b2d;
    endfunction

    always @(posedge clk) begin : cmd_decode
        logic [23:0] key;
        logic [15:0] w;
        key   = {pins.ba, open_row[pins.ba], pins.a[8:0]};
        w     = mem.exists(key) ? mem[key] : fill_word(key);
        rd_d1 <= rd_d0;  // Second CAS stage
        case (pins.cmd)
            ACTIVE: begin
                open_row[pins.ba] <= pins.a;
            end
            READ: begin
                rd_d0 <= w;
            end
            WRITE: begin
                if (pins.dq_oe) begin
                    if (!pins.dqm[0]) w[7:0] = pins.din[7:0];   // DQM high masks the byte
                    if (!pins.dqm[1]) w[15:8] = pins.din[15:8];
                    mem[key] = w;
                end
            end
            default: ;
        endcase
    end

    assign dq_in = rd_d1;

endmodule

`default_nettype wire

//--- verification/tb_game_test.sv
/* Testbench for game_test: download, bank reads and writes,
   round-robin, refresh, init and video timing checks */
`timescale 1ns/1ps
`default_nettype none

module tb_game_test;
    import sdram_pkg::*;

    localparam int max_cycles = 20000;

    logic        clk = 1'b0;
    logic        rst_n;
    bank_req_t   req_q [nbanks];
    bank_req_t   [nbanks-1:0] banks;
    logic [3:0]  ack, rdy;
    logic [15:0] dout, dq_in;
    logic        downloading, ioctl_wr, dwnld_busy, sdram_init;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    sdram_pins_t pins;
    logic        pxl_cen, pxl2_cen, lhbl, lvbl, hs, vs;

    int          cyc = 0;
    int          data_errs = 0;
    int          mon_errs;
    logic        dl_phase;  // Programming writes may hit any bank
    logic [15:0] ref_data [logic [23:0]];
    logic [1:0]  ref_known [logic [23:0]];
    logic [23:0] dl_keys [$];

    // Monitor state
    sdram_cmd_e  init_cmds [$];
    logic        init_l, lhbl_l, rf_armed;
    int          rf_cnt;
    logic [3:0]  pend;
    logic [3:0]  passed [nbanks];  // passed[m][n]: n served while m waited
    int          ack_cyc [nbanks];
    int          exp_dly [nbanks];
    int          cen_gap, cen2_gap;  // Cycles since the last pixel enables
    int          ref_h, ref_v;       // Raster position, one step per pixel
    int          hs_px, vs_ln;

    assign banks = {req_q[3], req_q[2], req_q[1], req_q[0]};

    game_test dut (.*);
    sdram_model u_mem (.clk(clk), .pins(pins), .dq_in(dq_in));

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= max_cycles) begin
            $display("Run stopped, no finish after %0d cycles", cyc);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            mon_errs = 0;
            init_l   = 1'b1;
            lhbl_l   = 1'b1;
            rf_armed = 1'b0;
            rf_cnt   = 0;
            pend     = '0;
            cen_gap  = 0;
            cen2_gap = 0;
            ref_h    = 0;
            ref_v    = 0;
            hs_px    = 0;
            vs_ln    = 0;
            for (int m = 0; m < nbanks; m++) passed[m] = '0;
        end else begin
            if (sdram_init && pins.cmd != NOP) init_cmds.push_back(pins.cmd);
            if (sdram_init && pins.cmd == PRECHARGE)
                assert (pins.a[10]) else begin
                    mon_errs++;
                    $display("Init precharge at %0t without A10 set", $time);
                end
            if (sdram_init)
                assert (pins.cmd != ACTIVE) else begin
                    mon_errs++;
                    $display("ACTIVE issued during init at %0t", $time);
                end
            if (init_l && !sdram_init)
                assert (init_cmds.size() == 4 && init_cmds[0] == PRECHARGE &&
                        init_cmds[1] == REFRESH && init_cmds[2] == REFRESH &&
                        init_cmds[3] == MODE) else begin
                    mon_errs++;
                    $display("Init command sequence wrong, %0d commands", init_cmds.size());
                end
            assert (pins.cke) else begin
                mon_errs++;
                $display("CKE low at %0t", $time);
            end
            // Data bus driven only with WRITE
            assert (pins.dq_oe == (pins.cmd == WRITE)) else begin
                mon_errs++;
                $display("MISMATCH at %0t: pins.dq_oe %b expected %b",
                         $time, pins.dq_oe, pins.cmd == WRITE);
            end
            // One refresh per line
            if (!sdram_init && pins.cmd == REFRESH) rf_cnt++;
            if (!sdram_init && lhbl_l && !lhbl) begin
                if (rf_armed)
                    assert (rf_cnt == 1) else begin
                        mon_errs++;
                        $display("%0d refreshes in the line ending at %0t", rf_cnt, $time);
                    end
                rf_armed = 1'b1;
                rf_cnt   = 0;
            end
            if (downloading)
                assert (ack == 4'b0) else begin
                    mon_errs++;
                    $display("Bank ack during download at %0t", $time);
                end
            if (pins.cmd == WRITE && !dl_phase)
                assert (pins.ba == 2'd0) else begin
                    mon_errs++;
                    $display("WRITE to bank %0d at %0t", pins.ba, $time);
                end
            for (int n = 0; n < nbanks; n++) begin
                if (ack[n]) begin
                    assert (!pend[n]) else begin
                        mon_errs++;
                        $display("Port %0d acked twice before rdy at %0t", n, $time);
                    end
                    for (int m = 0; m < nbanks; m++) begin
                        assert (!passed[m][n]) else begin
                            mon_errs++;
                            $display("Port %0d served twice while port %0d waited", n, m);
                        end
                        if (m != n && (banks[m].rd || banks[m].wr)) passed[m][n] = 1'b1;
                    end
                    passed[n]  = '0;
                    pend[n]    = 1'b1;
                    ack_cyc[n] = cyc;
                    exp_dly[n] = (n == 0 && banks[n].wr) ? 2 : 5;  // Write rdy at WRITE
                end
                if (rdy[n]) begin
                    assert (pend[n]) else begin
                        mon_errs++;
                        $display("Port %0d rdy without ack at %0t", n, $time);
                    end
                    assert (cyc - ack_cyc[n] == exp_dly[n]) else begin
                        mon_errs++;
                        $display("MISMATCH at %0t: rdy[%0d] delay %0d expected %0d",
                                 $time, n, cyc - ack_cyc[n], exp_dly[n]);
                    end
                    pend[n] = 1'b0;
                end
            end
            // Raster reference
            assert (lhbl == (ref_h < h_active)) else begin
                mon_errs++;
                $display("MISMATCH at %0t: lhbl %b expected %b", $time, lhbl, ref_h < h_active);
            end
            assert (lvbl == (ref_v < v_active)) else begin
                mon_errs++;
                $display("MISMATCH at %0t: lvbl %b expected %b", $time, lvbl, ref_v < v_active);
            end
            assert (!hs || ref_h >= h_active) else begin
                mon_errs++;
                $display("HS outside the line blank at %0t", $time);
            end
            assert (!vs || ref_v >= v_active) else begin
                mon_errs++;
                $display("VS outside the frame blank at %0t", $time);
            end
            assert (!pxl_cen || pxl2_cen) else begin
                mon_errs++;
                $display("pxl_cen without pxl2_cen at %0t", $time);
            end
            if (pxl2_cen) begin
                assert (cen2_gap == pxl_div / 2) else begin
                    mon_errs++;
                    $display("MISMATCH at %0t: pxl2_cen period %0d expected %0d",
                             $time, cen2_gap, pxl_div / 2);
                end
                cen2_gap = 1;
            end else begin
                cen2_gap++;
            end
            if (pxl_cen) begin
                assert (cen_gap == pxl_div) else begin
                    mon_errs++;
                    $display("MISMATCH at %0t: pxl_cen period %0d expected %0d",
                             $time, cen_gap, pxl_div);
                end
                cen_gap = 1;
                if (hs) hs_px++;
                if (ref_h == h_total - 1) begin  // End of line
                    assert (hs_px == 4) else begin
                        mon_errs++;
                        $display("HS lasted %0d pixels in the line ending at %0t", hs_px, $time);
                    end
                    if (vs) vs_ln++;
                    if (ref_v == v_total - 1) begin
                        assert (vs_ln == 4) else begin
                            mon_errs++;
                            $display("VS lasted %0d lines in the frame ending at %0t",
                                     vs_ln, $time);
                        end
                        vs_ln = 0;
                    end
                    hs_px = 0;
                    ref_h = 0;
                    ref_v = (ref_v + 1) % v_total;
                end else begin
                    ref_h++;
                end
            end else begin
                cen_gap++;
            end
            init_l = sdram_init;
            lhbl_l = lhbl;
        end
    end

    // Byte enables active low
    task automatic ref_write(input logic [23:0] k, input logic [15:0] d, input logic [1:0] m);
        logic [15:0] w;
        logic [1:0]  kn;
        w  = ref_data.exists(k) ? ref_data[k] : 16'h0;
        kn = ref_known.exists(k) ? ref_known[k] : 2'b00;
        if (!m[0]) begin
            w[7:0] = d[7:0];
            kn[0]  = 1'b1;
        end
        if (!m[1]) begin
            w[15:8] = d[15:8];
            kn[1]   = 1'b1;
        end
        ref_data[k]  = w;
        ref_known[k] = kn;
    endtask

    task automatic check_word(input string name, input logic [23:0] k, input logic [15:0] got);
        logic [15:0] mask;
        logic [15:0] exp;
        mask = {{8{ref_known[k][1]}}, {8{ref_known[k][0]}}};
        exp  = ref_data[k];
        assert (((got ^ exp) & mask) == 16'h0) else begin
            data_errs++;
            $display("MISMATCH at %0t: %s got %h expected %h (mask %h)",
                     $time, name, got, exp, mask);
        end
    endtask

    task automatic download_byte(input logic [24:0] a, input logic [7:0] d);
        do @(posedge clk); while (dwnld_busy);
        #5;
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #5 ioctl_wr = 1'b0;
        assert (dwnld_busy) else begin
            mon_errs++;
            $display("dwnld_busy low after a host write at %0t", $time);
        end
        ref_write({a[24:23], a[22:1]}, {d, d}, a[0] ? 2'b01 : 2'b10);
    endtask

    task automatic bank_access(input int n, input logic [21:0] a, input logic wr,
                               input logic [15:0] d, input logic [1:0] m,
                               output logic [15:0] q);
        @(posedge clk);
        #5;
        req_q[n].addr  = a;
        req_q[n].rd    = !wr;
        req_q[n].wr    = wr;
        req_q[n].din   = d;
        req_q[n].din_m = m;
        do @(posedge clk); while (!ack[n]);
        #5;
        req_q[n].rd = 1'b0;
        req_q[n].wr = 1'b0;
        do @(posedge clk); while (!rdy[n]);
        q = dout;
    endtask

    // Back-to-back reads on one port, each from that port's bank
    task automatic port_reads(input int n, input int rounds);
        logic [15:0] q;
        for (int r = 0; r < rounds; r++) begin
            bank_access(n, dl_keys[4*r+n][21:0], 1'b0, 16'h0, 2'b00, q);
            check_word("dout round-robin", dl_keys[4*r+n], q);
        end
    endtask

    initial begin
        logic [24:0] a;
        logic [23:0] k;
        logic [15:0] d;
        logic [15:0] q;
        logic [1:0]  masks [3];
        void'($urandom(96317));
        masks = '{2'b01, 2'b10, 2'b11};
        rst_n = 1'b0;
        downloading = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        dl_phase = 1'b0;
        for (int n = 0; n < nbanks; n++) req_q[n] = '0;
        repeat (4) @(posedge clk);
        #5 rst_n = 1'b1;
        do @(posedge clk); while (sdram_init);

        // Download with all bank ports requesting
        #5;
        dl_phase = 1'b1;
        downloading = 1'b1;
        for (int n = 0; n < nbanks; n++) req_q[n].rd = 1'b1;
        for (int i = 0; i < 64; i++) begin
            a = {2'(i % 4), 23'($urandom)};
            dl_keys.push_back({a[24:23], a[22:1]});
            download_byte(a, 8'($urandom));
        end
        do @(posedge clk); while (dwnld_busy);
        #5;
        for (int n = 0; n < nbanks; n++) req_q[n].rd = 1'b0;
        @(posedge clk);
        #5 downloading = 1'b0;
        repeat (8) @(posedge clk);
        #5 dl_phase = 1'b0;

        foreach (dl_keys[i]) begin
            k = dl_keys[i];
            bank_access(int'(k[23:22]), k[21:0], 1'b0, 16'h0, 2'b00, q);
            check_word("dout readback", k, q);
        end

        // Masked writes on bank 0
        k = {2'b00, 22'($urandom)};
        d = 16'($urandom);
        bank_access(0, k[21:0], 1'b1, d, 2'b00, q);
        ref_write(k, d, 2'b00);
        for (int i = 0; i < 3; i++) begin
            d = 16'($urandom);
            bank_access(0, k[21:0], 1'b1, d, masks[i], q);
            ref_write(k, d, masks[i]);
            bank_access(0, k[21:0], 1'b0, 16'h0, 2'b00, q);
            check_word("dout merged", k, q);
        end
        for (int n = 1; n < nbanks; n++)
            bank_access(n, 22'($urandom), 1'b1, 16'($urandom), 2'b00, q);

        // Four ports at once, each asking again as soon as it is served
        fork
            port_reads(0, 6);
            port_reads(1, 6);
            port_reads(2, 6);
            port_reads(3, 6);
        join

        // Idle through a vertical blank, refresh keeps running
        do @(posedge clk); while (lvbl);
        do @(posedge clk); while (!lvbl);
        #5;
        $display("Checks done: %0d data mismatches, %0d protocol errors", data_errs, mon_errs);
        if (data_errs == 0 && mon_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
common/sdram_pkg.sv
sdram/sdram_ctrl.sv
sdram/sdram_arb.sv
rtl/rom_loader.sv
rtl/video_timing.sv
rtl/game_test.sv
verification/sdram_model.sv
verification/tb_game_test.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_game_test
FILELIST  := tb.f
SIM       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(SIM) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
